/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := core_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and address width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_INDEX_W 5

// First fetch address and the ADDI x0,x0,0 encoding
`define RESET_ADDRESS 32'h0000_0000
`define NOP_INSTR 32'h0000_0013

`endif

/* design/apb_store_master.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module apb_store_master (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::store_req_t store,
    input  logic                 pready,
    output core_pkg::apb_req_t   apb,
    output logic                 stall
);
    import core_pkg::*;

    store_state_e state;
    store_state_e phase;
    logic         done;

    // Setup is shown in the same cycle the store reaches execute
    always_comb
    begin
        if (state == ACCESS)
            phase = ACCESS;
        else if (store.valid)
            phase = SETUP;
        else
            phase = IDLE;
    end

    assign done = (phase == ACCESS) && pready;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= IDLE;
        else if (phase == SETUP)
            state <= ACCESS;
        else if (done)
            state <= IDLE;
    end

    // ------------------------------
    // Bus and pipeline hold
    // ------------------------------
    always_comb
    begin
        apb.psel = (phase != IDLE);
        apb.penable = (phase == ACCESS);
        apb.paddr = store.addr;
        apb.pwdata = store.data;
    end

    // Held until pready completes the access phase
    assign stall = store.valid && !done;

endmodule

/* design/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    // Major opcodes of the kept subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        STORE  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
    } alu_op_e;

    // APB transfer phase
    typedef enum logic [1:0] {
        IDLE, SETUP, ACCESS
    } store_state_e;

    typedef struct packed {
        alu_op_e                  alu_op;
        logic                     use_imm;
        logic                     is_lui;
        logic                     is_store;
        logic                     write_enable;
        logic [`REG_INDEX_W-1:0]  rd;
        logic [`REG_INDEX_W-1:0]  rs1;
        logic                     rs1_read;
        logic [`REG_INDEX_W-1:0]  rs2;
        logic                     rs2_read;
        logic [`XLEN-1:0]         imm;
    } decoded_instr_t;

    // Writeback bus into the register file
    typedef struct packed {
        logic                     enable;
        logic [`REG_INDEX_W-1:0]  index;
        logic [`XLEN-1:0]         data;
    } reg_write_t;

    typedef struct packed {
        logic                     valid;
        logic [`XLEN-1:0]         addr;
        logic [`XLEN-1:0]         data;
    } store_req_t;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic [`XLEN-1:0]         paddr;
        logic [`XLEN-1:0]         pwdata;
    } apb_req_t;

endpackage

/* design/core_top.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
    input  logic               clk,
    input  logic               reset,
    output logic [`XLEN-1:0]   imem_addr,
    input  logic [`XLEN-1:0]   imem_data,
    output core_pkg::apb_req_t apb,
    input  logic               pready
);
    import core_pkg::*;

    decoded_instr_t   instr;
    logic [`XLEN-1:0] read_data_1;
    logic [`XLEN-1:0] read_data_2;
    reg_write_t       write;
    store_req_t       store;
    logic             stall;

    fetch_decode_stage u_fetch_decode_stage (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .instr     (instr)
    );

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (instr.rs1),
        .read_index_2 (instr.rs2),
        .read_data_1  (read_data_1),
        .read_data_2  (read_data_2),
        .write        (write)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .instr       (instr),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .write       (write),
        .store       (store)
    );

    // Write-only data port
    apb_store_master u_apb_store_master (
        .clk    (clk),
        .reset  (reset),
        .store  (store),
        .pready (pready),
        .apb    (apb),
        .stall  (stall)
    );

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     stall,
    input  core_pkg::decoded_instr_t instr,
    input  logic [`XLEN-1:0]         read_data_1,
    input  logic [`XLEN-1:0]         read_data_2,
    output core_pkg::reg_write_t     write,
    output core_pkg::store_req_t     store
);
    import core_pkg::*;

    decoded_instr_t   ex_instr;
    logic [`XLEN-1:0] ex_rs1;
    logic [`XLEN-1:0] ex_rs2;
    logic [`XLEN-1:0] operand_1;
    logic [`XLEN-1:0] operand_2;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] ex_result;

    // Newest producer wins: execute, then writeback, then register file
    function automatic logic [`XLEN-1:0] forward_operand(
        input logic [`REG_INDEX_W-1:0] index,
        input logic                    used,
        input logic [`XLEN-1:0]        rf_data
    );
        logic [`XLEN-1:0] value;
        if (!used)
            value = '0;
        else if (ex_instr.write_enable && ex_instr.rd != '0 && ex_instr.rd == index)
            value = ex_result;
        else if (write.enable && write.index != '0 && write.index == index)
            value = write.data;
        else
            value = rf_data;
        return value;
    endfunction

    always_comb
    begin
        operand_1 = forward_operand(instr.rs1, instr.rs1_read, read_data_1);
        operand_2 = forward_operand(instr.rs2, instr.rs2_read, read_data_2);
    end

    // ------------------------------
    // Execute register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            ex_instr <= '0;
        else if (!stall)
            ex_instr <= instr;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            ex_rs1 <= operand_1;
            ex_rs2 <= operand_2;
        end
    end

    // ------------------------------
    // ALU
    // ------------------------------
    assign alu_b = ex_instr.use_imm ? ex_instr.imm : ex_rs2;

    always_comb
    begin
        case (ex_instr.alu_op)
            SUB:     alu_result = ex_rs1 - alu_b;
            AND:     alu_result = ex_rs1 & alu_b;
            OR:      alu_result = ex_rs1 | alu_b;
            XOR:     alu_result = ex_rs1 ^ alu_b;
            SLL:     alu_result = ex_rs1 << alu_b[4:0];
            SRL:     alu_result = ex_rs1 >> alu_b[4:0];
            SRA:     alu_result = $signed(ex_rs1) >>> alu_b[4:0];
            SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(ex_rs1) < $signed(alu_b)};
            SLTU:    alu_result = {{(`XLEN-1){1'b0}}, ex_rs1 < alu_b};
            default: alu_result = ex_rs1 + alu_b;
        endcase
    end

    assign ex_result = ex_instr.is_lui ? ex_instr.imm : alu_result;

    // Store address is rs1 + imm through the adder
    always_comb
    begin
        store.valid = ex_instr.is_store;
        store.addr = alu_result;
        store.data = ex_rs2;
    end

    // ------------------------------
    // Writeback register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset || stall)
            write.enable <= 1'b0;
        else
            write.enable <= ex_instr.write_enable;
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            write.index <= ex_instr.rd;
            write.data <= ex_result;
        end
    end

endmodule

/* design/fetch_decode_stage.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module fetch_decode_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    output logic [`XLEN-1:0]      imem_addr,
    input  logic [`XLEN-1:0]      imem_data,
    output core_pkg::decoded_instr_t instr
);
    import core_pkg::*;

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] ir;
    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             alt;
    logic             op_legal;
    alu_op_e          alu_op;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_u;

    // ------------------------------
    // Fetch
    // ------------------------------
    assign imem_addr = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= `RESET_ADDRESS;
            ir <= `NOP_INSTR;
        end
        else if (!stall)
        begin
            pc <= pc + 4;
            ir <= imem_data;
        end
    end

    // ------------------------------
    // Decode
    // ------------------------------
    assign opcode = opcode_e'(ir[6:0]);
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];
    // Bit 30 selects SUB and SRA; immediates only use it for shifts
    assign alt = ir[30] & ((opcode == OP) | (funct3 == 3'b101));
    assign op_legal = (funct7 == 7'b0000000) |
                      ((funct7 == 7'b0100000) & ((funct3 == 3'b000) | (funct3 == 3'b101)));

    assign imm_i = {{(`XLEN-12){ir[31]}}, ir[31:20]};
    assign imm_s = {{(`XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_u = {ir[31:12], 12'b0};

    always_comb
    begin
        case (funct3)
            3'b000:  alu_op = alt ? SUB : ADD;
            3'b001:  alu_op = SLL;
            3'b010:  alu_op = SLT;
            3'b011:  alu_op = SLTU;
            3'b100:  alu_op = XOR;
            3'b101:  alu_op = alt ? SRA : SRL;
            3'b110:  alu_op = OR;
            default: alu_op = AND;
        endcase
    end

    always_comb
    begin
        instr = '0;
        instr.alu_op = alu_op;
        instr.rd = ir[11:7];
        instr.rs1 = ir[19:15];
        instr.rs2 = ir[24:20];
        case (opcode)
            OP:
            begin
                instr.write_enable = op_legal;
                instr.rs1_read = op_legal;
                instr.rs2_read = op_legal;
            end
            OP_IMM:
            begin
                instr.use_imm = 1'b1;
                instr.write_enable = 1'b1;
                instr.rs1_read = 1'b1;
                instr.imm = imm_i;
            end
            LUI:
            begin
                instr.is_lui = 1'b1;
                instr.write_enable = 1'b1;
                instr.imm = imm_u;
            end
            STORE:
            begin
                // Word stores only, address computed by the ALU adder
                if (funct3 == 3'b010)
                begin
                    instr.alu_op = ADD;
                    instr.use_imm = 1'b1;
                    instr.is_store = 1'b1;
                    instr.rs1_read = 1'b1;
                    instr.rs2_read = 1'b1;
                    instr.imm = imm_s;
                end
            end
            default:
            begin
                instr.write_enable = 1'b0;
            end
        endcase
    end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module register_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`REG_INDEX_W-1:0] read_index_1,
    input  logic [`REG_INDEX_W-1:0] read_index_2,
    output logic [`XLEN-1:0]        read_data_1,
    output logic [`XLEN-1:0]        read_data_2,
    input  core_pkg::reg_write_t    write
);
    import core_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        // x0 is hardwired, writes to it are dropped
        else if (write.enable && write.index != '0)
        begin
            regs[write.index] <= write.data;
        end
    end

    assign read_data_1 = (read_index_1 == '0) ? '0 : regs[read_index_1];
    assign read_data_2 = (read_index_2 == '0) ? '0 : regs[read_index_2];

endmodule

/* sim.f */
+incdir+.
design/core_pkg.sv
design/fetch_decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/apb_store_master.sv
design/core_top.sv
tb/core_checker.sv
tb/core_tb.sv

/* tb/core_checker.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module core_checker #(
    parameter int MAX_STORES = 48
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [`XLEN-1:0]   imem_addr,
    input  core_pkg::apb_req_t apb,
    input  logic               pready,
    input  logic [`XLEN-1:0]   expected_addr [MAX_STORES],
    input  logic [`XLEN-1:0]   expected_data [MAX_STORES],
    input  int                 expected_count,
    output int                 store_count,
    output int                 mismatch_count,
    output int                 failure_count
);
    import core_pkg::*;

    logic             prev_setup;
    logic             prev_waiting;
    logic [`XLEN-1:0] prev_paddr;
    logic [`XLEN-1:0] prev_pwdata;
    logic             prev_hold;
    logic [`XLEN-1:0] prev_imem_addr;
    int               cycles_out_of_reset;

    always @(posedge clk)
    begin : watch_bus
        int               new_mismatches;
        int               new_failures;
        logic [`XLEN-1:0] expected_pc;
        new_mismatches = 0;
        new_failures = 0;
        if (reset)
        begin
            prev_setup <= 1'b0;
            prev_waiting <= 1'b0;
            cycles_out_of_reset <= 0;
            store_count <= 0;
            mismatch_count <= 0;
            failure_count <= 0;
        end
        else
        begin
            // Fetch starts at the reset address, steps one word, holds while a store waits
            if (cycles_out_of_reset == 0)
                expected_pc = `RESET_ADDRESS;
            else if (prev_hold)
                expected_pc = prev_imem_addr;
            else
                expected_pc = prev_imem_addr + 4;
            if (imem_addr !== expected_pc)
            begin
                $display("mismatch imem_addr: expected 0x%08h, got 0x%08h",
                         expected_pc, imem_addr);
                new_mismatches++;
            end

            // No store can reach execute in the first two cycles
            if (cycles_out_of_reset < 2 && apb.psel)
            begin
                $display("psel went high before any store could reach execute");
                new_failures++;
            end
            if (apb.penable && !apb.psel)
            begin
                $display("penable high while psel is low");
                new_failures++;
            end
            if (apb.penable && !prev_setup && !prev_waiting)
            begin
                $display("Access phase started without a setup phase");
                new_failures++;
            end
            if (prev_setup && !apb.penable)
            begin
                $display("Setup phase was not followed by an access phase");
                new_failures++;
            end
            if (prev_waiting && !apb.penable)
            begin
                $display("Access phase ended before pready was seen");
                new_failures++;
            end
            if ((prev_setup || prev_waiting) && apb.paddr !== prev_paddr)
            begin
                $display("mismatch paddr during transfer: held 0x%08h, now 0x%08h",
                         prev_paddr, apb.paddr);
                new_mismatches++;
            end
            if ((prev_setup || prev_waiting) && apb.pwdata !== prev_pwdata)
            begin
                $display("mismatch pwdata during transfer: held 0x%08h, now 0x%08h",
                         prev_pwdata, apb.pwdata);
                new_mismatches++;
            end

            // Completed transfers are checked in program order
            if (apb.psel && apb.penable && pready)
            begin
                if (store_count >= expected_count)
                begin
                    $display("Store to 0x%08h completed after the last expected store",
                             apb.paddr);
                    new_failures++;
                end
                else
                begin
                    if (apb.paddr !== expected_addr[store_count])
                    begin
                        $display("mismatch paddr store %0d: expected 0x%08h, got 0x%08h",
                                 store_count, expected_addr[store_count], apb.paddr);
                        new_mismatches++;
                    end
                    if (apb.pwdata !== expected_data[store_count])
                    begin
                        $display("mismatch pwdata store %0d: expected 0x%08h, got 0x%08h",
                                 store_count, expected_data[store_count], apb.pwdata);
                        new_mismatches++;
                    end
                end
                store_count <= store_count + 1;
            end

            prev_setup <= apb.psel && !apb.penable;
            prev_waiting <= apb.psel && apb.penable && !pready;
            prev_paddr <= apb.paddr;
            prev_pwdata <= apb.pwdata;
            // The pipeline waits from setup until the access phase sees pready
            prev_hold <= apb.psel && !(apb.penable && pready);
            prev_imem_addr <= imem_addr;
            if (cycles_out_of_reset < 2)
                cycles_out_of_reset <= cycles_out_of_reset + 1;
            mismatch_count <= mismatch_count + new_mismatches;
            failure_count <= failure_count + new_failures;
        end
    end

endmodule

/* tb/core_tb.sv */
`timescale 1ns/1ps
`include "core_config.svh"

module core_tb;
    import core_pkg::*;

    localparam int PROG_LEN = 48;
    localparam int RANDOM_LEN = PROG_LEN - 7;
    localparam int MEM_WORDS = 512;
    localparam int CYCLE_LIMIT = PROG_LEN * 8 + 100;
    localparam int DRAIN_CYCLES = 8;

    logic             clk;
    logic             reset = 1'b1;
    logic             pready = 1'b0;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    apb_req_t         apb;

    logic [31:0] lfsr_state = 32'h1a4b;
    logic [31:0] program_mem [MEM_WORDS];
    logic        pready_pattern [CYCLE_LIMIT];
    logic [31:0] expected_addr [PROG_LEN];
    logic [31:0] expected_data [PROG_LEN];
    int          expected_count = 0;
    int          cycle_count = 0;
    int          run_errors = 0;
    int          store_count;
    int          mismatch_count;
    int          failure_count;

    // ------------------------------
    // Random source
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 32'hA300_0000;
        return next;
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // ------------------------------
    // Program and reference model
    // ------------------------------
    // Random mix over x0..x7 followed by stores of x1..x7 to 0x100 + 4k
    function automatic void build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] imm;
        int          op_count;
        int          imm_count;
        op_count = 0;
        imm_count = 0;
        for (int i = 0; i < MEM_WORDS; i++)
            program_mem[i] = `NOP_INSTR;
        for (int i = 0; i < RANDOM_LEN; i++)
        begin
            rd = 5'(random_bits(3));
            rs1 = 5'(random_bits(3));
            rs2 = 5'(random_bits(3));
            case (2'(random_bits(2)))
                2'd0:
                begin
                    // funct3 walks all eight so every operation shows up
                    funct3 = 3'(op_count);
                    op_count++;
                    funct7 = 7'b0;
                    if (funct3 == 3'b000 || funct3 == 3'b101)
                        funct7[5] = 1'(random_bits(1));
                    program_mem[i] = {funct7, rs2, rs1, funct3, rd, OP};
                end
                2'd1:
                begin
                    funct3 = 3'(imm_count);
                    imm_count++;
                    if (funct3 == 3'b001)
                        imm = {7'b0, 5'(random_bits(5))};
                    else if (funct3 == 3'b101)
                        imm = {1'b0, 1'(random_bits(1)), 5'b0, 5'(random_bits(5))};
                    else
                        imm = 12'(random_bits(12));
                    program_mem[i] = {imm, rs1, funct3, rd, OP_IMM};
                end
                2'd2:
                    program_mem[i] = {20'(random_bits(20)), rd, LUI};
                default:
                begin
                    imm = 12'(random_bits(12));
                    program_mem[i] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
                end
            endcase
        end
        for (int k = 1; k < 8; k++)
        begin
            imm = 12'h100 + 12'(4 * k);
            program_mem[RANDOM_LEN + k - 1] = {imm[11:5], 5'(k), 5'd0, 3'b010, imm[4:0], STORE};
        end
    endfunction

    function automatic logic [31:0] alu_reference(
        input logic [2:0]  funct3,
        input logic        alt,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] r;
        case (funct3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = {31'b0, $signed(a) < $signed(b)};
            3'b011:  r = {31'b0, a < b};
            3'b100:  r = a ^ b;
            3'b101:
            begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // Interprets the program in order and fills the expected store list
    function automatic int run_reference();
        logic [31:0] regs [32];
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [4:0]  rd;
        int          count;
        count = 0;
        for (int r = 0; r < 32; r++)
            regs[r] = '0;
        for (int i = 0; i < PROG_LEN; i++)
        begin
            instr = program_mem[i];
            rd = instr[11:7];
            a = regs[instr[19:15]];
            b = regs[instr[24:20]];
            imm_i = {{20{instr[31]}}, instr[31:20]};
            imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            case (instr[6:0])
                OP:
                    regs[rd] = alu_reference(instr[14:12], instr[30], a, b);
                OP_IMM:
                    regs[rd] = alu_reference(instr[14:12],
                                             instr[30] && instr[14:12] == 3'b101, a, imm_i);
                LUI:
                    regs[rd] = {instr[31:12], 12'b0};
                STORE:
                begin
                    expected_addr[count] = a + imm_s;
                    expected_data[count] = b;
                    count++;
                end
                default:
                    ;
            endcase
            // x0 stays zero
            regs[0] = '0;
        end
        return count;
    endfunction

    // ------------------------------
    // Clock, memory, DUT and checker
    // ------------------------------
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign imem_data = program_mem[imem_addr[10:2]];

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count < CYCLE_LIMIT)
            pready <= pready_pattern[cycle_count];
    end

    core_top u_core_top (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .apb       (apb),
        .pready    (pready)
    );

    core_checker #(
        .MAX_STORES (PROG_LEN)
    ) u_core_checker (
        .clk            (clk),
        .reset          (reset),
        .imem_addr      (imem_addr),
        .apb            (apb),
        .pready         (pready),
        .expected_addr  (expected_addr),
        .expected_data  (expected_data),
        .expected_count (expected_count),
        .store_count    (store_count),
        .mismatch_count (mismatch_count),
        .failure_count  (failure_count)
    );

    initial
    begin
        build_program();
        expected_count = run_reference();
        for (int c = 0; c < CYCLE_LIMIT; c++)
            pready_pattern[c] = 1'(random_bits(1));
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        while (store_count < expected_count && cycle_count < CYCLE_LIMIT)
            @(posedge clk);
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles with %0d of %0d stores completed",
                     cycle_count, store_count, expected_count);
            run_errors++;
        end
        else
        begin
            // Let the pipeline drain so a duplicate store would still show
            repeat (DRAIN_CYCLES) @(posedge clk);
            if (store_count != expected_count)
            begin
                $display("Completed %0d stores but the program has %0d",
                         store_count, expected_count);
                run_errors++;
            end
        end
        $display("Errors: %0d mismatches, %0d protocol failures, %0d run failures",
                 mismatch_count, failure_count, run_errors);
        if (mismatch_count + failure_count + run_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
